// File: cmd_pkg.sv
`default_nettype none

package cmd_pkg;

    // Opcode in bits 7:6 of the command byte
    typedef enum logic [1:0] {
        op_rdreg  = 2'b00,
        op_rdcrc  = 2'b01,
        op_wrreg  = 2'b10,
        op_rddata = 2'b11
    } cmd_op_e;

    // One-hot sequencer state
    typedef enum logic [4:0] {
        st_idle      = 5'b00001,
        st_read_reg  = 5'b00010,
        st_write_reg = 5'b00100,
        st_read_data = 5'b01000,
        st_read_crc  = 5'b10000
    } seq_state_e;

    localparam int REG_ADDR_W = 6;
    localparam int STATUS_W   = 14;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [STATUS_W-1:0]   status_t;
    typedef logic [15:0]           tx_word_t;

    ////////////////////
    // Reply tags and register map
    ////////////////////
    localparam logic [1:0] RESP_STATUS  = 2'b01;
    localparam logic [7:0] RESP_REGDATA = 8'hC0;

    localparam reg_addr_t CFG_LAST_ADDR  = 6'h23;
    localparam reg_addr_t STATUS_LO_ADDR = 6'h24;
    localparam reg_addr_t STATUS_HI_ADDR = 6'h25;

    // Writable while sampling
    localparam reg_addr_t SAFE_ADDR_AFERST = 6'h12;
    localparam reg_addr_t SAFE_ADDR_13     = 6'h13;
    localparam reg_addr_t SAFE_ADDR_23     = 6'h23;

    // CRC-16-CCITT
    localparam tx_word_t CRC_INIT = 16'hFFFF;
    localparam tx_word_t CRC_POLY = 16'h1021;

    ////////////////////
    // Bundles
    ////////////////////
    typedef struct packed {
        logic       byte_rcvd;
        logic       word_rcvd;
        logic [7:0] cmd_byte;
        logic [7:0] data_byte;
    } spi_rx_t;

    typedef struct packed {
        logic       wr_en;
        reg_addr_t  addr;
        logic [7:0] value;
    } cfg_wr_t;

    // One word into the CRC, MSB first
    function automatic tx_word_t crc_next(input tx_word_t crc_in, input tx_word_t data_in);
        tx_word_t crc;
        crc = crc_in;
        for (int i = 15; i >= 0; i--) begin
            if (crc[15] ^ data_in[i]) begin
                crc = {crc[14:0], 1'b0} ^ CRC_POLY;
            end else begin
                crc = {crc[14:0], 1'b0};
            end
        end
        return crc;
    endfunction

endpackage

`default_nettype wire

// File: status_sync.sv
`timescale 1ns/1ps
`default_nettype none

module status_sync (
    input  wire               sck,
    input  wire               nrst,
    input  wire cmd_pkg::status_t status,
    input  wire               ensamp,
    output cmd_pkg::status_t  status_s,
    output logic              ensamp_s
);

    // First stage, may go metastable
    cmd_pkg::status_t status_meta;
    logic             ensamp_meta;

    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            status_meta <= '0;
            ensamp_meta <= 1'b0;
            status_s    <= '0;
            ensamp_s    <= 1'b0;
        end else begin
            status_meta <= status;
            ensamp_meta <= ensamp;
            // Second stage, safe to use in SCK domain
            status_s    <= status_meta;
            ensamp_s    <= ensamp_meta;
        end
    end

endmodule

`default_nettype wire

// File: cmd_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_sequencer (
    input  wire                      sck,
    input  wire                      nrst,
    input  wire                      cs,
    input  wire cmd_pkg::spi_rx_t    rx,
    input  wire cmd_pkg::status_t    status_s,
    input  wire cmd_pkg::tx_word_t   reg_rsp,
    input  wire cmd_pkg::tx_word_t   data_rsp,
    input  wire cmd_pkg::tx_word_t   crc_rsp,
    output cmd_pkg::seq_state_e      state,
    output cmd_pkg::reg_addr_t       reg_addr,
    output logic                     second_word,
    output cmd_pkg::tx_word_t        tx_buff
);

    cmd_pkg::seq_state_e next_state;
    cmd_pkg::cmd_op_e    op;
    logic                addr_zero;
    logic                cmd_start;

    // Command byte fields
    assign op        = cmd_pkg::cmd_op_e'(rx.cmd_byte[7:6]);
    assign addr_zero = (rx.cmd_byte[5:0] == '0);
    assign cmd_start = rx.byte_rcvd && (state == cmd_pkg::st_idle);

    ////////////////////
    // Next state
    ////////////////////
    always_comb begin
        next_state = state;
        unique case (state)
            cmd_pkg::st_idle: begin
                if (rx.byte_rcvd) begin
                    unique case (op)
                        cmd_pkg::op_rdreg: next_state = cmd_pkg::st_read_reg;
                        cmd_pkg::op_wrreg: next_state = cmd_pkg::st_write_reg;
                        // Burst and CRC need a zero address field
                        cmd_pkg::op_rddata: begin
                            if (addr_zero) begin
                                next_state = cmd_pkg::st_read_data;
                            end
                        end
                        cmd_pkg::op_rdcrc: begin
                            if (addr_zero) begin
                                next_state = cmd_pkg::st_read_crc;
                            end
                        end
                        default: next_state = cmd_pkg::st_idle;
                    endcase
                end
            end
            // Status word, then register data
            cmd_pkg::st_read_reg: begin
                if (rx.word_rcvd && second_word) begin
                    next_state = cmd_pkg::st_idle;
                end
            end
            cmd_pkg::st_write_reg,
            cmd_pkg::st_read_crc: begin
                if (rx.word_rcvd) begin
                    next_state = cmd_pkg::st_idle;
                end
            end
            // Burst runs until deselect
            cmd_pkg::st_read_data: next_state = cmd_pkg::st_read_data;
            default: next_state = cmd_pkg::st_idle;
        endcase
    end

    // Deselect overrides everything
    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            state <= cmd_pkg::st_idle;
        end else if (cs) begin
            state <= cmd_pkg::st_idle;
        end else begin
            state <= next_state;
        end
    end

    ////////////////////
    // Address and word count
    ////////////////////
    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            reg_addr    <= '0;
            second_word <= 1'b0;
        end else if (cmd_start) begin
            reg_addr    <= rx.cmd_byte[5:0];
            second_word <= 1'b0;
        end else if ((state == cmd_pkg::st_read_reg) && rx.word_rcvd) begin
            second_word <= 1'b1;
        end
    end

    // Reply word follows state directly
    always_comb begin
        unique case (state)
            cmd_pkg::st_read_reg: begin
                tx_buff = second_word ? reg_rsp : {status_s, cmd_pkg::RESP_STATUS};
            end
            cmd_pkg::st_read_data: tx_buff = data_rsp;
            cmd_pkg::st_read_crc:  tx_buff = crc_rsp;
            // Idle and write both ack with status
            default: tx_buff = {status_s, cmd_pkg::RESP_STATUS};
        endcase
    end

endmodule

`default_nettype wire

// File: reg_access.sv
`timescale 1ns/1ps
`default_nettype none

module reg_access #(
    parameter int CFG_BYTES = 36
) (
    input  wire                       sck,
    input  wire                       nrst,
    input  wire cmd_pkg::spi_rx_t     rx,
    input  wire cmd_pkg::seq_state_e  state,
    input  wire cmd_pkg::reg_addr_t   reg_addr,
    input  wire [CFG_BYTES*8-1:0]     cfg_data,
    input  wire cmd_pkg::status_t     status_s,
    input  wire                       ensamp_s,
    output cmd_pkg::tx_word_t         reg_rsp,
    output cmd_pkg::cfg_wr_t          cfg_wr
);

    logic               cfg_hit;
    logic               safe_hit;
    logic               wr_ok;
    logic [7:0]         rd_byte;
    logic               wr_en_q;
    cmd_pkg::reg_addr_t wr_addr_q;
    logic [7:0]         wr_value_q;

    ////////////////////
    // Read data
    ////////////////////
    assign cfg_hit = (reg_addr <= cmd_pkg::CFG_LAST_ADDR);

    always_comb begin
        if (cfg_hit) begin
            rd_byte = cfg_data[8*reg_addr +: 8];
        end else if (reg_addr == cmd_pkg::STATUS_LO_ADDR) begin
            rd_byte = status_s[7:0];
        end else if (reg_addr == cmd_pkg::STATUS_HI_ADDR) begin
            // Upper status bits, zero padded
            rd_byte = {{(16 - cmd_pkg::STATUS_W){1'b0}}, status_s[cmd_pkg::STATUS_W-1:8]};
        end else begin
            // Unmapped
            rd_byte = 8'h00;
        end
    end

    assign reg_rsp = {cmd_pkg::RESP_REGDATA, rd_byte};

    ////////////////////
    // Write protection
    ////////////////////
    // Registers that tolerate a change while sampling
    assign safe_hit = (reg_addr == cmd_pkg::SAFE_ADDR_AFERST) ||
                      (reg_addr == cmd_pkg::SAFE_ADDR_13) ||
                      (reg_addr == cmd_pkg::SAFE_ADDR_23);

    assign wr_ok = cfg_hit && (!ensamp_s || safe_hit);

    // Strobe, single cycle
    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= (state == cmd_pkg::st_write_reg) && rx.word_rcvd && wr_ok;
        end
    end

    // Address and value held until next write
    always_ff @(posedge sck) begin
        if ((state == cmd_pkg::st_write_reg) && rx.word_rcvd && wr_ok) begin
            wr_addr_q  <= reg_addr;
            wr_value_q <= rx.data_byte;
        end
    end

    assign cfg_wr = '{wr_en: wr_en_q, addr: wr_addr_q, value: wr_value_q};

endmodule

`default_nettype wire

// File: sample_readout.sv
`timescale 1ns/1ps
`default_nettype none

module sample_readout #(
    parameter int SAMPLE_WORDS = 8
) (
    input  wire                       sck,
    input  wire                       nrst,
    input  wire                       cs,
    input  wire cmd_pkg::spi_rx_t     rx,
    input  wire cmd_pkg::seq_state_e  state,
    input  wire [SAMPLE_WORDS*16-1:0] adc_data,
    output cmd_pkg::tx_word_t         data_rsp,
    output cmd_pkg::tx_word_t         crc_rsp,
    output logic                      fifo_pop
);

    localparam int CNT_W = (SAMPLE_WORDS > 1) ? $clog2(SAMPLE_WORDS) : 1;

    logic              in_burst;
    logic              in_burst_q;
    logic              burst_start;
    logic [CNT_W-1:0]  word_cnt;
    logic              last_word;
    logic              sample_done;
    cmd_pkg::tx_word_t crc_q;
    cmd_pkg::tx_word_t crc_base;

    assign in_burst    = (state == cmd_pkg::st_read_data);
    // First cycle of a burst
    assign burst_start = in_burst && !in_burst_q;
    assign last_word   = (word_cnt == CNT_W'(SAMPLE_WORDS - 1));

    ////////////////////
    // Word counter
    ////////////////////
    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            in_burst_q  <= 1'b0;
            word_cnt    <= '0;
            sample_done <= 1'b0;
        end else begin
            in_burst_q <= in_burst;
            if (!in_burst) begin
                word_cnt    <= '0;
                sample_done <= 1'b0;
            end else if (rx.word_rcvd) begin
                // Wrap into next sample
                word_cnt    <= last_word ? '0 : word_cnt + 1'b1;
                sample_done <= last_word;
            end
        end
    end

    // Lowest word first
    assign data_rsp = adc_data[16*word_cnt +: 16];

    ////////////////////
    // FIFO pop
    ////////////////////
    // Full sample, or a partial one cut by CS
    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            fifo_pop <= 1'b0;
        end else begin
            fifo_pop <= in_burst && ((rx.word_rcvd && last_word) || (cs && !sample_done));
        end
    end

    ////////////////////
    // CRC
    ////////////////////
    // Restart from init at burst entry
    assign crc_base = burst_start ? cmd_pkg::CRC_INIT : crc_q;

    always_ff @(posedge sck or negedge nrst) begin
        if (!nrst) begin
            crc_q <= cmd_pkg::CRC_INIT;
        end else if (in_burst && rx.word_rcvd) begin
            crc_q <= cmd_pkg::crc_next(crc_base, data_rsp);
        end else if (burst_start) begin
            crc_q <= cmd_pkg::CRC_INIT;
        end
    end

    // Held after burst for a later CRC read
    assign crc_rsp = crc_q;

endmodule

`default_nettype wire

// File: spi_cmd_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_top #(
    parameter int CFG_BYTES    = 36,
    parameter int SAMPLE_WORDS = 8
) (
    input  wire                       sck,
    input  wire                       nrst,
    input  wire                       cs,
    input  wire cmd_pkg::spi_rx_t     rx,
    input  wire [CFG_BYTES*8-1:0]     cfg_data,
    input  wire [SAMPLE_WORDS*16-1:0] adc_data,
    input  wire cmd_pkg::status_t     status,
    input  wire                       ensamp,
    output cmd_pkg::tx_word_t         tx_buff,
    output cmd_pkg::cfg_wr_t          cfg_wr,
    output logic                      fifo_pop
);

    // Synchronized inputs
    cmd_pkg::status_t    status_s;
    logic                ensamp_s;
    // Sequencer state
    cmd_pkg::seq_state_e state;
    cmd_pkg::reg_addr_t  reg_addr;
    // Candidate reply words
    cmd_pkg::tx_word_t   reg_rsp;
    cmd_pkg::tx_word_t   data_rsp;
    cmd_pkg::tx_word_t   crc_rsp;

    status_sync status_sync_i (
        .sck      (sck),
        .nrst     (nrst),
        .status   (status),
        .ensamp   (ensamp),
        .status_s (status_s),
        .ensamp_s (ensamp_s)
    );

    cmd_sequencer cmd_sequencer_i (
        .sck         (sck),
        .nrst        (nrst),
        .cs          (cs),
        .rx          (rx),
        .status_s    (status_s),
        .reg_rsp     (reg_rsp),
        .data_rsp    (data_rsp),
        .crc_rsp     (crc_rsp),
        .state       (state),
        .reg_addr    (reg_addr),
        .second_word (),
        .tx_buff     (tx_buff)
    );

    reg_access #(
        .CFG_BYTES (CFG_BYTES)
    ) reg_access_i (
        .sck      (sck),
        .nrst     (nrst),
        .rx       (rx),
        .state    (state),
        .reg_addr (reg_addr),
        .cfg_data (cfg_data),
        .status_s (status_s),
        .ensamp_s (ensamp_s),
        .reg_rsp  (reg_rsp),
        .cfg_wr   (cfg_wr)
    );

    sample_readout #(
        .SAMPLE_WORDS (SAMPLE_WORDS)
    ) sample_readout_i (
        .sck      (sck),
        .nrst     (nrst),
        .cs       (cs),
        .rx       (rx),
        .state    (state),
        .adc_data (adc_data),
        .data_rsp (data_rsp),
        .crc_rsp  (crc_rsp),
        .fifo_pop (fifo_pop)
    );

endmodule

`default_nettype wire

// File: spi_cmd_tb.sv
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_tb;

    localparam int CFG_BYTES    = 36;
    localparam int SAMPLE_WORDS = 8;
    // Longest wait for a strobe, in SCK cycles
    localparam int WAIT_LIMIT   = 20;

    logic                       sck;
    logic                       nrst;
    logic                       cs;
    cmd_pkg::spi_rx_t           rx;
    logic [CFG_BYTES*8-1:0]     cfg_data;
    logic [SAMPLE_WORDS*16-1:0] adc_data;
    cmd_pkg::status_t           status;
    logic                       ensamp;
    cmd_pkg::tx_word_t          tx_buff;
    cmd_pkg::cfg_wr_t           cfg_wr;
    logic                       fifo_pop;

    int                wr_count = 0;
    int                pop_count = 0;
    cmd_pkg::cfg_wr_t  last_wr;
    int                mismatches = 0;
    int                timeouts = 0;
    cmd_pkg::tx_word_t crc_model;

    spi_cmd_top #(
        .CFG_BYTES    (CFG_BYTES),
        .SAMPLE_WORDS (SAMPLE_WORDS)
    ) spi_cmd_top_i (
        .sck      (sck),
        .nrst     (nrst),
        .cs       (cs),
        .rx       (rx),
        .cfg_data (cfg_data),
        .adc_data (adc_data),
        .status   (status),
        .ensamp   (ensamp),
        .tx_buff  (tx_buff),
        .cfg_wr   (cfg_wr),
        .fifo_pop (fifo_pop)
    );

    initial begin
        sck = 1'b0;
        forever #2 sck = ~sck;
    end

    // Pulse counters, sampling the value held over the last cycle
    always @(posedge sck) begin
        if (cfg_wr.wr_en) begin
            wr_count <= wr_count + 1;
            last_wr  <= cfg_wr;
        end
        if (fifo_pop) begin
            pop_count <= pop_count + 1;
        end
    end

    ////////////////////
    // Compare tasks
    ////////////////////
    task automatic check_word(input string name, input cmd_pkg::tx_word_t got,
                              input cmd_pkg::tx_word_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_wr(input cmd_pkg::cfg_wr_t got, input cmd_pkg::cfg_wr_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("CHECK FAILED cfg_wr got %h expected %h", got, exp);
        end
    endtask

    task automatic check_count(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    ////////////////////
    // Model
    ////////////////////
    function automatic logic [7:0] model_reg(input cmd_pkg::reg_addr_t a);
        if (a <= 6'h23) begin
            return cfg_data[8*a +: 8];
        end else if (a == 6'h24) begin
            return status[7:0];
        end else if (a == 6'h25) begin
            return {2'b00, status[13:8]};
        end
        return 8'h00;
    endfunction

    // In range, and one of three safe registers while sampling
    function automatic logic write_allowed(input cmd_pkg::reg_addr_t a, input logic samp);
        return (a <= 6'h23) && (!samp || a == 6'h12 || a == 6'h13 || a == 6'h23);
    endfunction

    ////////////////////
    // SPI side stimulus
    ////////////////////
    task automatic send_cmd(input logic [7:0] cmd);
        cs = 1'b0;
        @(negedge sck);
        rx.byte_rcvd = 1'b1;
        rx.cmd_byte  = cmd;
        @(negedge sck);
        rx.byte_rcvd = 1'b0;
    endtask

    // One word strobe, then a random idle gap
    task automatic send_word(input logic [7:0] data);
        int gap;
        gap = int'($urandom % 3);
        rx.word_rcvd = 1'b1;
        rx.data_byte = data;
        @(negedge sck);
        rx.word_rcvd = 1'b0;
        @(negedge sck);
        repeat (gap) @(negedge sck);
    endtask

    task automatic end_xfer();
        cs = 1'b1;
        @(negedge sck);
        @(negedge sck);
    endtask

    // Bounded wait for both counters, then a short look for extra pulses
    task automatic wait_counts(input int wr_target, input int pop_target);
        int n;
        n = 0;
        while ((wr_count < wr_target || pop_count < pop_target) && n < WAIT_LIMIT) begin
            @(negedge sck);
            n++;
        end
        if (wr_count < wr_target || pop_count < pop_target) begin
            timeouts++;
            $display("Timeout: no write strobe or FIFO pop within %0d cycles", WAIT_LIMIT);
        end
        @(negedge sck);
        @(negedge sck);
    endtask

    // Register read, status word first and register data second
    task automatic do_read(input cmd_pkg::reg_addr_t rd_addr);
        send_cmd({2'b00, rd_addr});
        check_word("tx_buff", tx_buff, {status, cmd_pkg::RESP_STATUS});
        send_word(8'h00);
        check_word("tx_buff", tx_buff, {cmd_pkg::RESP_REGDATA, model_reg(rd_addr)});
        send_word(8'h00);
        end_xfer();
    endtask

    task automatic do_write(input cmd_pkg::reg_addr_t wr_addr, input logic [7:0] wr_value);
        int base_wr;
        logic ok;
        ok = write_allowed(wr_addr, ensamp);
        base_wr = wr_count;
        send_cmd({2'b10, wr_addr});
        check_word("tx_buff", tx_buff, {status, cmd_pkg::RESP_STATUS});
        send_word(wr_value);
        end_xfer();
        wait_counts(base_wr + (ok ? 1 : 0), pop_count);
        check_count("wr_en pulses", wr_count - base_wr, ok ? 1 : 0);
        if (ok) begin
            check_wr(last_wr, '{wr_en: 1'b1, addr: wr_addr, value: wr_value});
        end
    endtask

    // Burst of n words, checked word by word against adc_data
    task automatic do_burst(input int n);
        cmd_pkg::tx_word_t exp;
        int base_pop;
        base_pop = pop_count;
        crc_model = cmd_pkg::CRC_INIT;
        send_cmd(8'hC0);
        for (int w = 0; w < n; w++) begin
            exp = adc_data[16*w +: 16];
            check_word("tx_buff", tx_buff, exp);
            crc_model = cmd_pkg::crc_next(crc_model, exp);
            send_word(8'h00);
        end
        // Full sample pops before deselect, a cut one only on it
        if (n == SAMPLE_WORDS) begin
            wait_counts(wr_count, base_pop + 1);
        end
        check_count("fifo_pop pulses", pop_count - base_pop, (n == SAMPLE_WORDS) ? 1 : 0);
        end_xfer();
        wait_counts(wr_count, base_pop + 1);
        check_count("fifo_pop pulses", pop_count - base_pop, 1);
    endtask

    task automatic read_crc();
        send_cmd(8'h40);
        check_word("tx_buff", tx_buff, crc_model);
        send_word(8'h00);
        end_xfer();
    endtask

    ////////////////////
    // Test sequence
    ////////////////////
    initial begin
        int                 seed;
        int                 base_pop;

        seed = $urandom(32'hebeb);
        nrst = 1'b0;
        cs = 1'b1;
        rx = '0;
        adc_data = '0;
        status = '0;
        ensamp = 1'b0;
        for (int i = 0; i < CFG_BYTES; i++) begin
            cfg_data[8*i +: 8] = 8'($urandom);
        end
        repeat (4) @(negedge sck);
        nrst = 1'b1;
        @(negedge sck);

        // Reset values
        check_word("tx_buff", tx_buff, 16'h0001);
        check_count("cfg_wr.wr_en", 32'(cfg_wr.wr_en), 0);
        check_count("fifo_pop", 32'(fifo_pop), 0);

        // Status through two sync stages
        status = 14'($urandom);
        repeat (3) @(negedge sck);

        // Both status fields, then random addresses
        do_read(6'h24);
        do_read(6'h25);
        for (int i = 0; i < 24; i++) begin
            do_read(6'($urandom));
        end

        // Writes, not sampling
        for (int i = 0; i < 20; i++) begin
            do_write(6'($urandom), 8'($urandom));
        end

        // Writes while sampling, safe addresses first
        ensamp = 1'b1;
        repeat (3) @(negedge sck);
        do_write(6'h12, 8'($urandom));
        do_write(6'h13, 8'($urandom));
        do_write(6'h23, 8'($urandom));
        for (int i = 0; i < 20; i++) begin
            do_write(6'($urandom), 8'($urandom));
        end
        ensamp = 1'b0;
        repeat (3) @(negedge sck);

        // Full and cut bursts, each followed by a CRC read
        for (int b = 0; b < 6; b++) begin
            for (int w = 0; w < SAMPLE_WORDS; w++) begin
                adc_data[16*w +: 16] = 16'($urandom);
            end
            do_burst((b % 2 == 0) ? SAMPLE_WORDS : 1 + int'($urandom % 7));
            read_crc();
        end

        // Burst command with an address field is ignored
        base_pop = pop_count;
        send_cmd({2'b11, 6'($urandom % 63 + 1)});
        check_word("tx_buff", tx_buff, {status, cmd_pkg::RESP_STATUS});
        send_word(8'h00);
        check_word("tx_buff", tx_buff, {status, cmd_pkg::RESP_STATUS});
        end_xfer();
        wait_counts(wr_count, base_pop);
        check_count("fifo_pop pulses", pop_count - base_pop, 0);
        // CRC still from the last real burst
        read_crc();

        $display("Closing: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
cmd_pkg.sv
status_sync.sv
cmd_sequencer.sv
reg_access.sv
sample_readout.sv
spi_cmd_top.sv
spi_cmd_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= spi_cmd_tb
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Pass or fail comes from the log, not the simulator exit code
run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)
